// File: hdl/accelPkg.sv
package accelPkg;

    // data word and register width
    localparam int dataWidth = 16;
    // general registers r0 to r7
    localparam int regCount = 8;

    // arithmetic class, codes 0 to 3
    localparam logic [3:0] opAdd = 4'd0;
    localparam logic [3:0] opSub = 4'd1;
    localparam logic [3:0] opMul = 4'd2;
    localparam logic [3:0] opDiv = 4'd3;
    // logic class, shifts and rotates by one
    localparam logic [3:0] opShl = 4'd4;
    localparam logic [3:0] opShr = 4'd5;
    localparam logic [3:0] opRol = 4'd6;
    localparam logic [3:0] opRor = 4'd7;
    // bitwise
    localparam logic [3:0] opAnd = 4'd8;
    localparam logic [3:0] opOr = 4'd9;
    localparam logic [3:0] opXor = 4'd10;
    localparam logic [3:0] opNor = 4'd11;
    localparam logic [3:0] opNand = 4'd12;
    localparam logic [3:0] opXnor = 4'd13;
    // unsigned compares, result 1 or 0
    localparam logic [3:0] opGt = 4'd14;
    localparam logic [3:0] opEq = 4'd15;

    // word addresses on the bus
    localparam logic [3:0] addrAcc = 4'd0;
    localparam logic [3:0] addrInstr = 4'd1;
    localparam logic [3:0] addrStatus = 4'd2;
    // r0 at 8 through r7 at 15
    localparam logic [3:0] addrRegBase = 4'd8;

    // one instruction word, two readings selected by immFlag
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic immFlag;
            logic [7:0] unused;
            logic [2:0] regSel;
        } regForm;
        struct packed {
            logic [3:0] opcode;
            logic immFlag;
            logic [10:0] imm;
        } immForm;
    } instrWord;

endpackage

// File: hdl/arithUnit.sv
`timescale 1ns/1ps

module arithUnit (
    input  logic clk,
    input  logic rst,
    input  logic exec,
    input  logic [3:0] opcode,
    input  logic [accelPkg::dataWidth-1:0] operandA,
    input  logic [accelPkg::dataWidth-1:0] operandB,
    output logic [accelPkg::dataWidth-1:0] arithResult,
    output logic done,
    output logic divZero
);
    import accelPkg::*;

    // divider running
    logic busy;
    // iteration counter, all ones on the last step
    logic [$clog2(dataWidth)-1:0] count;
    // partial remainder, dividend shifting into quotient
    logic [dataWidth-1:0] remainder;
    logic [dataWidth-1:0] quotient;
    logic [dataWidth-1:0] divisor;
    logic [dataWidth-1:0] product;
    // restoring step
    logic [dataWidth:0] shifted;
    logic [dataWidth:0] trial;
    logic quotientBit;

    // only the low half is kept
    assign product = operandA * operandB;

    always_comb begin
        // bring next dividend bit into the remainder
        shifted = {remainder, quotient[dataWidth-1]};
        trial = shifted - {1'b0, divisor};
        // no borrow means divisor fits
        quotientBit = ~trial[dataWidth];
    end

    // control, done pulses for one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            count <= '0;
            done <= 1'b0;
            divZero <= 1'b0;
        end else begin
            done <= 1'b0;
            divZero <= 1'b0;
            if (busy) begin
                count <= count + 1'b1;
                if (&count) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (exec) begin
                if (opcode == opDiv && operandB != '0) begin
                    busy <= 1'b1;
                    count <= '0;
                end else begin
                    // single cycle ops, logic class included
                    done <= 1'b1;
                    divZero <= (opcode == opDiv);
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (busy) begin
            remainder <= quotientBit ? trial[dataWidth-1:0] : shifted[dataWidth-1:0];
            quotient <= {quotient[dataWidth-2:0], quotientBit};
            // last step goes straight to the result
            if (&count)
                arithResult <= {quotient[dataWidth-2:0], quotientBit};
        end else if (exec) begin
            case (opcode)
                opAdd: arithResult <= operandA + operandB;
                opSub: arithResult <= operandA - operandB;
                opMul: arithResult <= product;
                opDiv: begin
                    // all ones for divide by zero
                    arithResult <= '1;
                    remainder <= '0;
                    quotient <= operandA;
                    divisor <= operandB;
                end
                default: arithResult <= '0;
            endcase
        end
    end

endmodule

// File: hdl/logicUnit.sv
`timescale 1ns/1ps

module logicUnit (
    input  logic [3:0] opcode,
    input  logic [accelPkg::dataWidth-1:0] operandA,
    input  logic [accelPkg::dataWidth-1:0] operandB,
    output logic [accelPkg::dataWidth-1:0] logicResult
);
    import accelPkg::*;

    // purely combinational, same encodings as the arithmetic side
    always_comb begin
        case (opcode)
            // one position, zero fill
            opShl: logicResult = {operandA[dataWidth-2:0], 1'b0};
            opShr: logicResult = {1'b0, operandA[dataWidth-1:1]};
            // msb wraps to lsb
            opRol: logicResult = {operandA[dataWidth-2:0], operandA[dataWidth-1]};
            // lsb wraps to msb
            opRor: logicResult = {operandA[0], operandA[dataWidth-1:1]};
            opAnd: logicResult = operandA & operandB;
            opOr: logicResult = operandA | operandB;
            opXor: logicResult = operandA ^ operandB;
            opNor: logicResult = ~(operandA | operandB);
            opNand: logicResult = ~(operandA & operandB);
            opXnor: logicResult = ~(operandA ^ operandB);
            // unsigned compares
            opGt: begin
                if (operandA > operandB)
                    logicResult = dataWidth'(1);
                else
                    logicResult = '0;
            end
            opEq: begin
                if (operandA == operandB)
                    logicResult = dataWidth'(1);
                else
                    logicResult = '0;
            end
            // arithmetic class handled elsewhere
            default: logicResult = '0;
        endcase
    end

endmodule

// File: hdl/accCore.sv
`timescale 1ns/1ps

module accCore (
    input  logic clk,
    input  logic rst,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  logic [3:0] adr,
    input  logic [accelPkg::dataWidth-1:0] datIn,
    output logic [accelPkg::dataWidth-1:0] datOut,
    output logic ack,
    output logic exec,
    output logic [3:0] opcode,
    output logic [accelPkg::dataWidth-1:0] operandA,
    output logic [accelPkg::dataWidth-1:0] operandB,
    input  logic [accelPkg::dataWidth-1:0] arithResult,
    input  logic [accelPkg::dataWidth-1:0] logicResult,
    input  logic done,
    input  logic divZero
);
    import accelPkg::*;

    logic [dataWidth-1:0] regFile [regCount];
    logic [dataWidth-1:0] acc;
    instrWord lastInstr;
    // instruction seen by the units
    instrWord curInstr;
    // sticky until a status write
    logic divZeroFlag;
    // fsm: idle, waiting on done, ack (ack flop is the ack state)
    logic waitState;
    logic idle;
    logic request;
    logic [dataWidth-1:0] readData;

    assign idle = !waitState && !ack;
    // new access accepted only in idle
    assign request = idle && cyc && stb;
    // execute starts in the accept cycle
    assign exec = request && we && (adr == addrInstr);

    always_comb begin
        // bus word while accepting, stored copy while waiting
        if (idle)
            curInstr = datIn;
        else
            curInstr = lastInstr;
    end

    // opcode sits in the same bits for both forms
    assign opcode = curInstr.regForm.opcode;
    assign operandA = acc;

    always_comb begin
        if (curInstr.immForm.immFlag)
            operandB = dataWidth'(curInstr.immForm.imm);
        else
            operandB = regFile[curInstr.regForm.regSel];
    end

    // read mux, unmapped addresses give zero
    always_comb begin
        readData = '0;
        if (adr >= addrRegBase)
            readData = regFile[adr[$clog2(regCount)-1:0]];
        else if (adr == addrAcc)
            readData = acc;
        else if (adr == addrInstr)
            readData = lastInstr;
        else if (adr == addrStatus)
            readData = {{(dataWidth-1){1'b0}}, divZeroFlag};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            waitState <= 1'b0;
            acc <= '0;
            lastInstr <= '0;
            divZeroFlag <= 1'b0;
            for (int i = 0; i < regCount; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            ack <= 1'b0;
            if (exec) begin
                // hold here until the units finish
                waitState <= 1'b1;
                lastInstr <= datIn;
            end else if (request) begin
                // plain access, ack next cycle
                ack <= 1'b1;
                if (we) begin
                    if (adr >= addrRegBase)
                        regFile[adr[$clog2(regCount)-1:0]] <= datIn;
                    else if (adr == addrAcc)
                        acc <= datIn;
                    else if (adr == addrStatus)
                        divZeroFlag <= 1'b0;
                end
            end
            if (waitState && done) begin
                waitState <= 1'b0;
                ack <= 1'b1;
                // codes 0 to 3 take the arithmetic result
                if (opcode <= opDiv)
                    acc <= arithResult;
                else
                    acc <= logicResult;
                if (divZero)
                    divZeroFlag <= 1'b1;
            end
        end
    end

    // read data lands with ack
    always_ff @(posedge clk) begin
        if (request)
            datOut <= readData;
    end

endmodule

// File: hdl/accelTop.sv
`timescale 1ns/1ps

module accelTop (
    input  logic clk,
    input  logic rst,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  logic [3:0] adr,
    input  logic [accelPkg::dataWidth-1:0] datIn,
    output logic [accelPkg::dataWidth-1:0] datOut,
    output logic ack
);
    import accelPkg::*;

    // core to units
    logic exec;
    logic [3:0] opcode;
    logic [dataWidth-1:0] operandA;
    logic [dataWidth-1:0] operandB;
    // units back to core
    logic [dataWidth-1:0] arithResult;
    logic [dataWidth-1:0] logicResult;
    logic done;
    logic divZero;

    // bus slave, registers and accumulator
    accCore accCore_i (
        .clk(clk),
        .rst(rst),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .datIn(datIn),
        .datOut(datOut),
        .ack(ack),
        .exec(exec),
        .opcode(opcode),
        .operandA(operandA),
        .operandB(operandB),
        .arithResult(arithResult),
        .logicResult(logicResult),
        .done(done),
        .divZero(divZero)
    );

    // add, sub, mul and iterative divide
    arithUnit arithUnit_i (
        .clk(clk),
        .rst(rst),
        .exec(exec),
        .opcode(opcode),
        .operandA(operandA),
        .operandB(operandB),
        .arithResult(arithResult),
        .done(done),
        .divZero(divZero)
    );

    // shifts, bitwise, compares
    logicUnit logicUnit_i (
        .opcode(opcode),
        .operandA(operandA),
        .operandB(operandB),
        .logicResult(logicResult)
    );

endmodule

// File: sim/accelTop_chk.sv
`timescale 1ns/1ps

module accelTopChk (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack
);

    // slave answers only a live request
    ackInCycle: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
        else $error("ack seen without cyc and stb");

    // one ack per request
    ackOnePulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack high for two cycles in a row");

    // reset clears the handshake
    ackAfterReset: assert property (@(posedge clk) rst |=> !ack)
        else $error("ack high in the cycle after reset");

endmodule

bind accelTop accelTopChk accelTopChk_i (
    .clk(clk),
    .rst(rst),
    .cyc(cyc),
    .stb(stb),
    .ack(ack)
);

// File: sim/accelTb.sv
`timescale 1ns/1ps

module accelTb;
    import accelPkg::*;

    localparam int clkPeriod = 4;
    // cycles allowed for one bus access
    localparam int accessLimit = 40;
    localparam int numOps = 12;
    // reset, registers, logic and arith ops, divide by zero, readback
    localparam int accessCount = 11 + 23 + 2 * 3 * numOps + 9 + 4;

    logic clk = 1'b0;
    logic rst;
    logic cyc;
    logic stb;
    logic we;
    logic [3:0] adr;
    logic [dataWidth-1:0] datIn;
    logic [dataWidth-1:0] datOut;
    logic ack;

    // shadow of the DUT state
    logic [dataWidth-1:0] shAcc;
    logic [dataWidth-1:0] shRegs [regCount];
    logic shFlag;
    instrWord shInstr;

    // reads waiting for the comparator
    string nameQ[$];
    logic [dataWidth-1:0] expQ[$];
    logic [dataWidth-1:0] actQ[$];
    event readDone;

    integer seed = 32'h6202;
    int errors = 0;
    int checks = 0;
    int testErrors = 0;
    int testCount = 0;

    accelTop accelTop_i (.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datIn(datIn), .datOut(datOut), .ack(ack));

    always #(clkPeriod / 2) clk = ~clk;

    // expected {flag, accumulator} for one instruction
    function automatic logic [dataWidth:0] refExec(logic [3:0] op, logic [dataWidth-1:0] a,
                                                   logic [dataWidth-1:0] b);
        logic [dataWidth-1:0] r;
        logic flag;
        flag = 1'b0;
        case (op)
            opAdd: r = a + b;
            opSub: r = a - b;
            // low half of the product only
            opMul: r = a * b;
            opDiv: begin
                if (b == '0) begin
                    r = '1;
                    flag = 1'b1;
                end else begin
                    r = a / b;
                end
            end
            opShl: r = a << 1;
            opShr: r = a >> 1;
            opRol: r = (a << 1) | (a >> (dataWidth - 1));
            opRor: r = (a >> 1) | (a << (dataWidth - 1));
            opAnd: r = a & b;
            opOr: r = a | b;
            opXor: r = a ^ b;
            opNor: r = ~(a | b);
            opNand: r = ~(a & b);
            opXnor: r = ~(a ^ b);
            opGt: r = dataWidth'(a > b);
            default: r = dataWidth'(a == b);
        endcase
        return {flag, r};
    endfunction

    // register or zero-extended immediate
    function automatic logic [dataWidth-1:0] operandOf(instrWord w);
        if (w.immForm.immFlag)
            return dataWidth'(w.immForm.imm);
        return shRegs[w.regForm.regSel];
    endfunction

    // random word, opcode limited to one class
    function automatic instrWord randomInstr(int opLow, int opSpan);
        instrWord w;
        w = 16'($random(seed));
        w.regForm.opcode = 4'(opLow + {$random(seed)} % opSpan);
        return w;
    endfunction

    // one classic cycle, starts 1 ns after an edge
    task automatic busAccess(input logic write, input logic [3:0] addr,
                             input logic [dataWidth-1:0] wdata, output logic [dataWidth-1:0] rdata);
        int n;
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = addr;
        datIn = wdata;
        n = 0;
        // ack looked at mid cycle
        do begin
            @(negedge clk);
            n++;
        end while (!ack && n < accessLimit);
        assert (ack) else begin
            errors++;
            $display("no acknowledge for address %0d within %0d cycles", addr, accessLimit);
        end
        rdata = datOut;
        // hold through the edge that samples ack
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic writeBus(input logic [3:0] addr, input logic [dataWidth-1:0] data);
        logic [dataWidth-1:0] unused;
        busAccess(1'b1, addr, data, unused);
    endtask

    task automatic readBus(input string name, input logic [3:0] addr,
                           input logic [dataWidth-1:0] expected);
        logic [dataWidth-1:0] rdata;
        busAccess(1'b0, addr, '0, rdata);
        nameQ.push_back(name);
        expQ.push_back(expected);
        actQ.push_back(rdata);
        ->readDone;
    endtask

    // run one instruction, then check the accumulator
    task automatic execInstr(input instrWord w);
        logic [dataWidth:0] res;
        res = refExec(w.regForm.opcode, shAcc, operandOf(w));
        writeBus(addrInstr, w);
        shAcc = res[dataWidth-1:0];
        shFlag = shFlag | res[dataWidth];
        shInstr = w;
        readBus("acc", addrAcc, shAcc);
    endtask

    // spare cycle lets the comparator drain
    task automatic endTest(input string name);
        @(posedge clk);
        #1;
        $display("test %0d %-20s %s, %0d errors", testCount, name,
                 (errors == testErrors) ? "ok" : "bad", errors - testErrors);
        testCount++;
        testErrors = errors;
    endtask

    // comparator
    always @(readDone) begin
        while (actQ.size() > 0) begin
            checks++;
            assert (actQ[0] === expQ[0]) else begin
                errors++;
                $display("** Error at %0t: %s expected %h, got %h",
                         $time, nameQ[0], expQ[0], actQ[0]);
            end
            nameQ.delete(0);
            expQ.delete(0);
            actQ.delete(0);
        end
    end

    initial begin
        instrWord w;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datIn = '0;
        rst = 1'b1;
        shAcc = '0;
        shFlag = 1'b0;
        shInstr = '0;
        for (int i = 0; i < regCount; i++)
            shRegs[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // everything reads zero out of reset
        readBus("acc", addrAcc, shAcc);
        readBus("status", addrStatus, dataWidth'(shFlag));
        readBus("instr", addrInstr, shInstr);
        for (int i = 0; i < regCount; i++)
            readBus($sformatf("r%0d", i), 4'(addrRegBase + i), shRegs[i]);
        endTest("reset state");

        for (int i = 0; i < regCount; i++) begin
            shRegs[i] = 16'($random(seed));
            writeBus(4'(addrRegBase + i), shRegs[i]);
        end
        shAcc = 16'($random(seed));
        writeBus(addrAcc, shAcc);
        for (int i = 0; i < regCount; i++)
            readBus($sformatf("r%0d", i), 4'(addrRegBase + i), shRegs[i]);
        readBus("acc", addrAcc, shAcc);
        // 3 to 7 are holes in the map
        for (int a = 3; a < 8; a++)
            readBus("unmapped", 4'(a), '0);
        endTest("registers");

        for (int i = 0; i < numOps; i++) begin
            shAcc = 16'($random(seed));
            writeBus(addrAcc, shAcc);
            execInstr(randomInstr(opShl, 12));
        end
        endTest("logic ops");

        for (int i = 0; i < numOps; i++) begin
            shAcc = 16'($random(seed));
            writeBus(addrAcc, shAcc);
            w = randomInstr(opAdd, 4);
            // zero divisor gets a test of its own
            if (w.regForm.opcode == opDiv && operandOf(w) == '0) begin
                w.immForm.immFlag = 1'b1;
                w.immForm.imm = 11'd1;
            end
            execInstr(w);
        end
        endTest("arith ops");

        shAcc = 16'($random(seed));
        writeBus(addrAcc, shAcc);
        w = '0;
        w.immForm.opcode = opDiv;
        w.immForm.immFlag = 1'b1;
        execInstr(w);
        readBus("status", addrStatus, dataWidth'(shFlag));
        // flag is sticky across a later add
        w.immForm.opcode = opAdd;
        w.immForm.imm = 11'd5;
        execInstr(w);
        readBus("status", addrStatus, dataWidth'(shFlag));
        writeBus(addrStatus, '0);
        shFlag = 1'b0;
        readBus("status", addrStatus, dataWidth'(shFlag));
        endTest("divide by zero");

        readBus("instr", addrInstr, shInstr);
        execInstr(randomInstr(opShl, 12));
        readBus("instr", addrInstr, shInstr);
        endTest("instr readback");

        $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // every access at its limit, plus reset and test gaps
    initial begin
        #((accessCount * accessLimit + 20) * clkPeriod);
        $display("watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sources.f
hdl/accelPkg.sv
hdl/arithUnit.sv
hdl/logicUnit.sv
hdl/accCore.sv
hdl/accelTop.sv
sim/accelTop_chk.sv
sim/accelTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module accelTb -f sources.f -o accelSim \
    && ./obj_dir/accelSim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
grep -q ">>> PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
